// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := fftAccelTb
FILELIST  := sources.f

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := obj_dir/V$(TOP)
LOG       := sim.log

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: rtl/addressGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module addressGenerator #(
    parameter int pointCount = 16
) (
    input  logic [$clog2($clog2(pointCount))-1:0] stage,
    input  logic [$clog2(pointCount)-2:0]         bfly,
    output logic [$clog2(pointCount)-1:0]         idxA,
    output logic [$clog2(pointCount)-1:0]         idxB,
    output logic [$clog2(pointCount)-2:0]         twIdx
);
    localparam int idxWidth  = $clog2(pointCount);
    localparam int bflyWidth = idxWidth - 1;
    localparam int stages    = idxWidth;

    always_comb begin
        logic [idxWidth-1:0] ext;
        logic [idxWidth-1:0] lowMask;
        ext     = {1'b0, bfly};
        lowMask = (idxWidth'(1) << stage) - idxWidth'(1); // position inside the group
        // zero bit at the stage position, half-span sets it
        idxA  = ((ext & ~lowMask) << 1) | (ext & lowMask);
        idxB  = idxA | (idxWidth'(1) << stage);
        // W of span 2^(stage+1) on the full circle
        twIdx = (bfly & lowMask[bflyWidth-1:0]) << (stages - 1 - stage);
    end

endmodule

`default_nettype wire

// File: rtl/butterflyUnit.sv
`timescale 1ns/1ps
`default_nettype none

module butterflyUnit (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  inVld,
    input  logic                                  inverse,
    input  fftPkg::cplxWord                       inA,
    input  fftPkg::cplxWord                       inB,
    input  logic signed [fftPkg::sampleWidth-1:0] twRe,
    input  logic signed [fftPkg::sampleWidth-1:0] twIm,
    output fftPkg::cplxWord                       outA,
    output fftPkg::cplxWord                       outB,
    output logic                                  outValid
);
    import fftPkg::*;

    localparam int fracBits = sampleWidth - 1;
    localparam int accWidth = 2 * sampleWidth + 2;     // A plus a full complex product
    localparam logic signed [accWidth-1:0] roundHalf = accWidth'(1) <<< fracBits;

    logic signed [2*sampleWidth-1:0] prodRR, prodII, prodIR, prodRI;
    logic signed [accWidth-1:0]      wbRe, wbIm, aRe, aIm;
    logic signed [accWidth-1:0]      sumRe, sumIm, difRe, difIm;

    assign prodRR = inB.re * twRe;
    assign prodII = inB.im * twIm;
    assign prodIR = inB.im * twRe;
    assign prodRI = inB.re * twIm;

    always_comb begin
        if (inverse) begin                             // B times conj(W)
            wbRe = prodRR + prodII;
            wbIm = prodIR - prodRI;
        end else begin
            wbRe = prodRR - prodII;
            wbIm = prodIR + prodRI;
        end
        aRe   = inA.re;
        aIm   = inA.im;
        sumRe = (aRe <<< fracBits) + wbRe + roundHalf; // one rounding covers the halving
        sumIm = (aIm <<< fracBits) + wbIm + roundHalf;
        difRe = (aRe <<< fracBits) - wbRe + roundHalf;
        difIm = (aIm <<< fracBits) - wbIm + roundHalf;
    end

    always_ff @(posedge clk) begin
        outA.re <= sumRe[2*sampleWidth-1:sampleWidth]; // divide by 2^16
        outA.im <= sumIm[2*sampleWidth-1:sampleWidth];
        outB.re <= difRe[2*sampleWidth-1:sampleWidth];
        outB.im <= difIm[2*sampleWidth-1:sampleWidth];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            outValid <= 1'b0;
        else
            outValid <= inVld;
    end

endmodule

`default_nettype wire

// File: rtl/fftAccel.sv
`timescale 1ns/1ps
`default_nettype none

module fftAccel #(
    parameter int pointCount = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cyc,
    input  logic                        stb,
    input  logic                        we,
    input  logic [$clog2(pointCount):0] adr,
    input  fftPkg::cplxWord             datWr,
    output fftPkg::cplxWord             datRd,
    output logic                        ack,
    output logic                        done
);
    import fftPkg::*;
    import wbPkg::*;

    localparam int idxWidth   = $clog2(pointCount);
    localparam int stageWidth = $clog2(idxWidth);
    localparam int bflyWidth  = idxWidth - 1;

    regSel                         sel, rdSel;
    logic                          req, hostWr, ctrlWr, startReq;
    logic [idxWidth-1:0]           hostWrIdx, ramIdxA;
    logic                          ctrlInvQ, doneBit;
    logic [2*sampleWidth-1:0]      regWord;
    logic                          busy, issue, inverse, issueQ, outValid;
    logic [stageWidth-1:0]         stage;
    logic [bflyWidth-1:0]          bfly, twIdx;
    logic [idxWidth-1:0]           idxA, idxB, wrIdxA;
    logic [idxWidth-1:0]           idxAPipe [2];
    logic [idxWidth-1:0]           idxBPipe [2];
    logic signed [sampleWidth-1:0] twRe, twIm;
    cplxWord                       rdA, rdB, bflyA, bflyB, wrA;
    logic                          wrEnA;

    ////////////////////
    // bus decode
    ////////////////////

    always_comb begin
        if (!adr[idxWidth])
            sel = dataWin;
        else if (adr[idxWidth-1:0] == idxWidth'(ctrlOffset))
            sel = ctrlReg;
        else
            sel = statReg;                             // any other register address
    end

    assign req      = cyc && stb && !ack;              // first cycle of a request
    assign hostWr   = req && we && (sel == dataWin) && !busy;
    assign ctrlWr   = req && we && (sel == ctrlReg) && !busy;
    assign startReq = ctrlWr && datWr[ctrlStartBit];

    always_comb begin
        for (int i = 0; i < idxWidth; i++)
            hostWrIdx[i] = adr[idxWidth-1-i];          // load in DIT order
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack      <= 1'b0;
            rdSel    <= dataWin;
            regWord  <= '0;
            ctrlInvQ <= 1'b0;
        end else begin
            ack <= req;                                // one clock, low between cycles
            if (req) begin
                rdSel   <= sel;
                regWord <= '0;
                if (sel == ctrlReg)
                    regWord[ctrlInvBit] <= ctrlInvQ;
                else if (sel == statReg) begin
                    regWord[statBusyBit] <= busy;
                    regWord[statDoneBit] <= doneBit;
                end
            end
            if (ctrlWr)
                ctrlInvQ <= datWr[ctrlInvBit];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            doneBit <= 1'b0;
        else if (startReq)
            doneBit <= 1'b0;
        else if (done)
            doneBit <= 1'b1;
    end

    assign datRd = (rdSel == dataWin) ? rdA : cplxWord'(regWord);

    ////////////////////
    // compute path
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            issueQ <= 1'b0;
        else
            issueQ <= issue;                           // RAM and twiddle now valid
    end

    always_ff @(posedge clk) begin
        idxAPipe[0] <= idxA;
        idxAPipe[1] <= idxAPipe[0];
        idxBPipe[0] <= idxB;
        idxBPipe[1] <= idxBPipe[0];
    end

    assign ramIdxA = busy ? idxA : adr[idxWidth-1:0];  // host reads natural order
    assign wrEnA   = outValid || hostWr;
    assign wrIdxA  = outValid ? idxAPipe[1] : hostWrIdx;
    assign wrA     = outValid ? bflyA : datWr;

    fftControl #(.pointCount(pointCount)) uControl (
        .clk(clk), .rst(rst), .start(startReq), .inverseReq(datWr[ctrlInvBit]),
        .busy(busy), .issue(issue), .inverse(inverse), .done(done),
        .stage(stage), .bfly(bfly));

    addressGenerator #(.pointCount(pointCount)) uAgen (
        .stage(stage), .bfly(bfly), .idxA(idxA), .idxB(idxB), .twIdx(twIdx));

    twiddleRom #(.pointCount(pointCount)) uRom (
        .clk(clk), .twIdx(twIdx), .twRe(twRe), .twIm(twIm));

    butterflyUnit uBfly (
        .clk(clk), .rst(rst), .inVld(issueQ), .inverse(inverse),
        .inA(rdA), .inB(rdB), .twRe(twRe), .twIm(twIm),
        .outA(bflyA), .outB(bflyB), .outValid(outValid));

    fftRam #(.pointCount(pointCount)) uRam (
        .clk(clk), .idxA(ramIdxA), .idxB(idxB), .rdA(rdA), .rdB(rdB),
        .wrEnA(wrEnA), .wrEnB(outValid), .wrIdxA(wrIdxA), .wrIdxB(idxBPipe[1]),
        .wrA(wrA), .wrB(bflyB));

    // the master holds its request up to the edge that sees ack
    assert property (@(posedge clk) disable iff (rst)
        ack |-> (cyc && stb))
        else $error("fftAccel: ack without cyc and stb");

endmodule

`default_nettype wire

// File: rtl/fftControl.sv
`timescale 1ns/1ps
`default_nettype none

module fftControl #(
    parameter int pointCount = 16
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start,
    input  logic                                  inverseReq,
    output logic                                  busy,
    output logic                                  issue,
    output logic                                  inverse,
    output logic                                  done,
    output logic [$clog2($clog2(pointCount))-1:0] stage,
    output logic [$clog2(pointCount)-2:0]         bfly
);
    import fftPkg::*;

    localparam int stages     = $clog2(pointCount);
    localparam int stageWidth = $clog2(stages);

    ctrlState state;
    logic     drainCnt;                                // two drain cycles per stage

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            stage    <= '0;
            bfly     <= '0;
            drainCnt <= 1'b0;
            inverse  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state   <= compute;
                        stage   <= '0;
                        bfly    <= '0;
                        inverse <= inverseReq;         // held for the whole run
                    end
                end
                compute: begin
                    bfly <= bfly + 1'b1;               // wraps to 0 for the next stage
                    if (&bfly) begin
                        state    <= drain;
                        drainCnt <= 1'b0;
                    end
                end
                drain: begin
                    drainCnt <= 1'b1;
                    if (drainCnt) begin
                        if (stage == stageWidth'(stages - 1)) begin
                            state <= finish;
                        end else begin
                            stage <= stage + 1'b1;
                            state <= compute;
                        end
                    end
                end
                default: state <= idle;                // finish
            endcase
        end
    end

    assign issue = (state == compute);
    assign busy  = (state != idle);
    assign done  = (state == finish);                  // single cycle, finish -> idle

    ////////////////////
    // checks
    ////////////////////

    // the last issue of a stage is followed by two quiet drain cycles
    assert property (@(posedge clk) disable iff (rst)
        $fell(issue) |-> (!issue && state == drain) [*2])
        else $error("fftControl: drain shorter than two cycles");

endmodule

`default_nettype wire

// File: rtl/fftPkg.sv
`default_nettype none

package fftPkg;

    ////////////////////
    // sample format
    ////////////////////

    localparam int sampleWidth = 16;                   // Q1.15 per part

    // one complex sample per bus word
    typedef struct packed {
        logic signed [sampleWidth-1:0] im;             // bits 31..16
        logic signed [sampleWidth-1:0] re;             // bits 15..0
    } cplxWord;

    ////////////////////
    // controller
    ////////////////////

    typedef enum logic [1:0] {
        idle,                                          // waiting for a start
        compute,                                       // one butterfly per clock
        drain,                                         // let the last writes land
        finish                                         // one cycle, raises done
    } ctrlState;

endpackage

`default_nettype wire

// File: rtl/fftRam.sv
`timescale 1ns/1ps
`default_nettype none

module fftRam #(
    parameter int pointCount = 16
) (
    input  logic                          clk,
    input  logic [$clog2(pointCount)-1:0] idxA,
    input  logic [$clog2(pointCount)-1:0] idxB,
    output fftPkg::cplxWord               rdA,
    output fftPkg::cplxWord               rdB,
    input  logic                          wrEnA,
    input  logic                          wrEnB,
    input  logic [$clog2(pointCount)-1:0] wrIdxA,
    input  logic [$clog2(pointCount)-1:0] wrIdxB,
    input  fftPkg::cplxWord               wrA,
    input  fftPkg::cplxWord               wrB
);
    import fftPkg::*;

    cplxWord mem [pointCount];

    always_ff @(posedge clk) begin
        rdA <= mem[idxA];                              // old data on a same-cycle write
        rdB <= mem[idxB];
        if (wrEnA)
            mem[wrIdxA] <= wrA;
        if (wrEnB)
            mem[wrIdxB] <= wrB;
    end

    ////////////////////
    // checks
    ////////////////////

    // the two delayed butterfly indices must stay apart on every write
    assert property (@(posedge clk) (wrEnA && wrEnB) |-> (wrIdxA != wrIdxB))
        else $error("fftRam: both write ports hit index %0d", wrIdxA);

endmodule

`default_nettype wire

// File: rtl/twiddleRom.sv
`timescale 1ns/1ps
`default_nettype none

module twiddleRom #(
    parameter int pointCount = 16
) (
    input  logic                                  clk,
    input  logic [$clog2(pointCount)-2:0]         twIdx,
    output logic signed [fftPkg::sampleWidth-1:0] twRe,
    output logic signed [fftPkg::sampleWidth-1:0] twIm
);
    import fftPkg::*;

    localparam int  halfCount = pointCount / 2;        // first half circle only
    localparam real pi        = 3.14159265358979;
    localparam real fullScale = 2.0 ** (sampleWidth - 1);

    logic signed [sampleWidth-1:0] cosTab    [halfCount];
    logic signed [sampleWidth-1:0] negSinTab [halfCount];

    // real to Q1.15, +1.0 clips to the top code
    function automatic logic signed [sampleWidth-1:0] toQ15(input real x);
        real scaled;
        scaled = x * fullScale;
        if (scaled >= fullScale - 1.0)
            return sampleWidth'($rtoi(fullScale - 1.0));
        return sampleWidth'($rtoi(scaled >= 0.0 ? scaled + 0.5 : scaled - 0.5));
    endfunction

    for (genvar k = 0; k < halfCount; k++) begin : genTab
        assign cosTab[k]    = toQ15($cos(2.0 * pi * k / pointCount));
        assign negSinTab[k] = toQ15(-$sin(2.0 * pi * k / pointCount));
    end

    always_ff @(posedge clk) begin
        twRe <= cosTab[twIdx];                          // lines up with the RAM read
        twIm <= negSinTab[twIdx];
    end

endmodule

`default_nettype wire

// File: rtl/wbPkg.sv
`default_nettype none

package wbPkg;

    // register words sit just above the data window at pointCount
    localparam int ctrlOffset = 0;
    localparam int statOffset = 1;

    typedef enum logic [1:0] {
        dataWin,                                       // sample RAM
        ctrlReg,                                       // start and inverse
        statReg                                        // busy and done
    } regSel;

    // control word
    localparam int ctrlStartBit = 0;
    localparam int ctrlInvBit   = 1;

    // status word
    localparam int statBusyBit = 0;
    localparam int statDoneBit = 1;

endpackage

`default_nettype wire

// File: sim/fftAccelTb.sv
`timescale 1ns/1ps
`default_nettype none

module fftAccelTb;
    import fftPkg::*;
    import wbPkg::*;

    localparam int     pointCount = 16;
    localparam int     adrWidth   = $clog2(pointCount) + 1;
    localparam int     ctrlAddr   = pointCount + ctrlOffset;
    localparam int     statAddr   = pointCount + statOffset;
    localparam int     numRows    = 7;
    localparam int     busClocks  = 2;                 // request clock plus ack clock
    localparam int     maxPolls   = 64;
    localparam longint timeoutNs  = numRows * (64 * busClocks + 100) * 40;
    localparam real    pi         = 3.14159265358979;

    typedef enum {constIn, impulseAt0, impulseAt1, randomIn, busyIn} stimKind;

    typedef struct {
        string   name;
        stimKind kind;
        bit      inverse;
        int      amp;
        int      tol;                                  // 0 means exact match
    } testRow;

    logic                clk;
    logic                rst;
    logic                cyc;
    logic                stb;
    logic                we;
    logic [adrWidth-1:0] adr;
    cplxWord             datWr;
    cplxWord             datRd;
    logic                ack;
    logic                done;

    testRow      rows [numRows];
    int          inRe [pointCount];
    int          inIm [pointCount];
    int          expRe [pointCount];
    int          expIm [pointCount];
    int          doneCount = 0;
    int          checkCount = 0;
    logic [31:0] rdWord;

    fftAccel #(.pointCount(pointCount)) uut (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datWr(datWr), .datRd(datRd), .ack(ack), .done(done));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (done === 1'b1)
            doneCount = doneCount + 1;                 // done lasts exactly one clock
    end

    initial begin
        #(timeoutNs);
        failRun("watchdog timeout: the tests did not finish in time");
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkValue(input string name, input int expected, input int actual);
        checkCount++;
        if (expected != actual)
            failRun($sformatf("CHECK FAILED %s expected %0d actual %0d", name, expected, actual));
    endtask

    function automatic int roundToInt(input real x);
        return (x >= 0.0) ? $rtoi(x + 0.5) : -$rtoi(0.5 - x);
    endfunction

    function automatic int absDiff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    // called on a falling edge, returns on a falling edge
    task automatic busWrite(input int addr, input logic [31:0] data);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = adrWidth'(addr);
        datWr = data;
        @(negedge clk);
        while (ack !== 1'b1)
            @(negedge clk);
        @(negedge clk);                                // slave sees ack on the edge in between
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic busRead(input int addr, output logic [31:0] data);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = adrWidth'(addr);
        @(negedge clk);
        while (ack !== 1'b1)
            @(negedge clk);
        data = datRd;
        @(negedge clk);
        cyc  = 1'b0;
        stb  = 1'b0;
    endtask

    task automatic waitDone();
        logic [31:0] stat;
        int          polls;
        polls = 0;
        do begin
            busRead(statAddr, stat);
            polls++;
            if (polls > maxPolls)
                failRun("transform did not finish: status never showed done");
        end while (!(stat[statDoneBit] && !stat[statBusyBit]));
    endtask

    ////////////////////
    // reference model
    ////////////////////

    task automatic loadSamples(input testRow row);
        for (int n = 0; n < pointCount; n++) begin
            inRe[n] = 0;
            inIm[n] = 0;
            case (row.kind)
                constIn:    inRe[n] = row.amp;
                impulseAt0: inRe[n] = (n == 0) ? row.amp : 0;
                impulseAt1: inRe[n] = (n == 1) ? row.amp : 0;
                default: begin                         // random within +-amp
                    inRe[n] = int'($urandom % (2 * row.amp)) - row.amp;
                    inIm[n] = int'($urandom % (2 * row.amp)) - row.amp;
                end
            endcase
        end
    endtask

    // DFT over pointCount, divided by pointCount
    task automatic computeExpected(input bit inv);
        real accRe;
        real accIm;
        real ang;
        real sgn;
        sgn = inv ? 1.0 : -1.0;
        for (int k = 0; k < pointCount; k++) begin
            accRe = 0.0;
            accIm = 0.0;
            for (int n = 0; n < pointCount; n++) begin
                ang   = sgn * 2.0 * pi * ((k * n) % pointCount) / pointCount;
                accRe += inRe[n] * $cos(ang) - inIm[n] * $sin(ang);
                accIm += inRe[n] * $sin(ang) + inIm[n] * $cos(ang);
            end
            expRe[k] = roundToInt(accRe / pointCount);
            expIm[k] = roundToInt(accIm / pointCount);
        end
    endtask

    task automatic runRow(input testRow row);
        logic [31:0] word;
        logic [31:0] ctrlWord;
        int          startCount;
        int          actRe;
        int          actIm;
        loadSamples(row);
        for (int n = 0; n < pointCount; n++)
            busWrite(n, {16'(inIm[n]), 16'(inRe[n])});
        ctrlWord               = '0;
        ctrlWord[ctrlStartBit] = 1'b1;
        ctrlWord[ctrlInvBit]   = row.inverse;
        startCount             = doneCount;
        busWrite(ctrlAddr, ctrlWord);
        if (row.kind == busyIn) begin
            busRead(statAddr, word);
            checkValue({row.name, " busy set"}, 1, int'(word[statBusyBit]));
            ctrlWord[ctrlInvBit] = ~row.inverse;
            busWrite(ctrlAddr, ctrlWord);              // second start, must be ignored
            for (int n = 0; n < pointCount / 2; n++)
                busWrite(n, 32'h7fff_7fff);            // dropped even between writebacks
        end
        waitDone();
        if (row.kind == busyIn) begin
            busRead(ctrlAddr, word);
            checkValue({row.name, " inverse kept"}, int'(row.inverse),
                int'(word[ctrlInvBit]));
        end
        computeExpected(row.inverse);
        for (int k = 0; k < pointCount; k++) begin
            busRead(k, word);
            actRe = int'($signed(word[15:0]));
            actIm = int'($signed(word[31:16]));
            if (row.tol == 0) begin
                checkValue($sformatf("%s bin %0d re", row.name, k), expRe[k], actRe);
                checkValue($sformatf("%s bin %0d im", row.name, k), expIm[k], actIm);
            end else begin
                checkValue($sformatf("%s bin %0d re near %0d got %0d", row.name, k,
                    expRe[k], actRe), 1, int'(absDiff(expRe[k], actRe) <= row.tol));
                checkValue($sformatf("%s bin %0d im near %0d got %0d", row.name, k,
                    expIm[k], actIm), 1, int'(absDiff(expIm[k], actIm) <= row.tol));
            end
        end
        checkValue({row.name, " done pulses"}, startCount + 1, doneCount);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        void'($urandom(32'h6638be21));
        rows[0] = '{"constFwd", constIn, 1'b0, 12000, 0};
        rows[1] = '{"impulse0Fwd", impulseAt0, 1'b0, 8000, 0};
        rows[2] = '{"impulse0Inv", impulseAt0, 1'b1, 8000, 0};
        rows[3] = '{"impulse1Fwd", impulseAt1, 1'b0, 16000, 2};
        rows[4] = '{"impulse1Inv", impulseAt1, 1'b1, 16000, 2};
        rows[5] = '{"randomFwd", randomIn, 1'b0, 16384, 4};
        rows[6] = '{"busyRun", busyIn, 1'b0, 16384, 4};
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        datWr = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkValue("reset ack", 0, int'(ack));
        checkValue("reset done", 0, int'(done));
        busRead(statAddr, rdWord);
        checkValue("reset busy", 0, int'(rdWord[statBusyBit]));
        foreach (rows[i])
            runRow(rows[i]);
        if (checkCount > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            failRun("no checks were run");
        end
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/fftPkg.sv
rtl/wbPkg.sv
rtl/twiddleRom.sv
rtl/butterflyUnit.sv
rtl/addressGenerator.sv
rtl/fftRam.sv
rtl/fftControl.sv
rtl/fftAccel.sv
sim/fftAccelTb.sv
